/* design/mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// instruction field bounds
`define OPC_HI   31
`define OPC_LO   26
`define RS_HI    25
`define RS_LO    21
`define RT_HI    20
`define RT_LO    16
`define RD_HI    15
`define RD_LO    11
`define SHAMT_HI 10
`define SHAMT_LO 6
`define FUNC_HI  5
`define FUNC_LO  0

`define LINK_REG 5'd31

`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_COP0     6'b010000
`define OP_SPECIAL2 6'b011100
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_LWL      6'b100010
`define OP_LW       6'b100011
`define OP_LBU      6'b100100
`define OP_LHU      6'b100101
`define OP_LWR      6'b100110
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_SWL      6'b101010
`define OP_SW       6'b101011
`define OP_SWR      6'b101110
`define OP_CACHE    6'b101111
`define OP_LL       6'b110000
`define OP_PREF     6'b110011
`define OP_SC       6'b111000

`define F_SLL  6'b000000
`define F_SRL  6'b000010
`define F_SRA  6'b000011
`define F_SLLV 6'b000100
`define F_SRLV 6'b000110
`define F_SRAV 6'b000111
`define F_JR   6'b001000
`define F_JALR 6'b001001
`define F_SYNC 6'b001111
`define F_ADD  6'b100000
`define F_ADDU 6'b100001
`define F_SUB  6'b100010
`define F_SUBU 6'b100011
`define F_AND  6'b100100
`define F_OR   6'b100101
`define F_XOR  6'b100110
`define F_NOR  6'b100111
`define F_SLT  6'b101010
`define F_SLTU 6'b101011

// REGIMM rt field
`define B_BLTZ   5'b00000
`define B_BGEZ   5'b00001
`define B_BLTZAL 5'b10000
`define B_BGEZAL 5'b10001

`endif

/* design/mips_isa_pkg.sv */
`include "mips_macros.svh"

package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  func_t;
    typedef logic [4:0]  shamt_t;

    function automatic opcode_t opcode_of(word_t w);
        return w[`OPC_HI:`OPC_LO];
    endfunction

    function automatic reg_addr_t rs_of(word_t w);
        return w[`RS_HI:`RS_LO];
    endfunction

    // also the REGIMM selector
    function automatic reg_addr_t rt_of(word_t w);
        return w[`RT_HI:`RT_LO];
    endfunction

    function automatic reg_addr_t rd_of(word_t w);
        return w[`RD_HI:`RD_LO];
    endfunction

    function automatic shamt_t shamt_of(word_t w);
        return w[`SHAMT_HI:`SHAMT_LO];
    endfunction

    function automatic func_t funct_of(word_t w);
        return w[`FUNC_HI:`FUNC_LO];
    endfunction

endpackage

/* design/decode_ctl_pkg.sv */
package decode_ctl_pkg;

    // zero value means nothing decoded
    typedef enum logic [5:0] {
        RESERVED,
        ADD, ADDU, SUB, SUBU, SLT, SLTU,
        AND, OR, XOR, NOR,
        SLL, SRL, SRA, SLLV, SRLV, SRAV,
        LUI,
        BEQ, BNE, BGEZ, BLTZ, BGEZAL, BLTZAL, BGTZ, BLEZ,
        J, JAL, JR, JALR,
        LB, LBU, LH, LHU, LW, LWL, LWR,
        SB, SH, SW, SWL, SWR
    } decoded_op_e;

    typedef enum logic [3:0] {
        ALU_ADDU,   // address calc uses the zero value
        ALU_ADD,
        ALU_SUBU,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_PASSA
    } alu_func_e;

    typedef enum logic [2:0] {
        T_BEQ,
        T_BNE,
        T_BGEZ,
        T_BLTZ,
        T_BGTZ,
        T_BLEZ
    } branch_type_e;

    typedef enum logic {
        REGB,
        IMM
    } alu_src_e;

    typedef struct packed {
        alu_func_e    alufunc;
        alu_src_e     alusrc;
        branch_type_e branch_type;
        logic         regwrite;
        logic         memtoreg;
        logic         memwrite;
        logic         zeroext;      // logical immediates
        logic         shamt_valid;  // shift by the shamt field
        logic         branch;
        logic         branch1;      // rs against zero
        logic         branch2;      // rs against rt
        logic         jump;
        logic         jr;
        logic         is_link;
    } control_t;

    typedef struct packed {
        decoded_op_e             op;
        control_t                ctl;
        mips_isa_pkg::reg_addr_t srcrega;
        mips_isa_pkg::reg_addr_t srcregb;
        mips_isa_pkg::reg_addr_t destreg;
        logic                    exception_ri;
    } decode_out_t;

endpackage

/* design/alu_op_decode.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module alu_op_decode (
    input  mips_isa_pkg::word_t         instr,
    output logic                        hit,
    output decode_ctl_pkg::decode_out_t result
);
    mips_isa_pkg::opcode_t     opcode;
    mips_isa_pkg::func_t       funct;
    mips_isa_pkg::reg_addr_t   rs;
    mips_isa_pkg::reg_addr_t   rt;
    mips_isa_pkg::reg_addr_t   rd;
    decode_ctl_pkg::decoded_op_e op;
    decode_ctl_pkg::alu_func_e alufunc;
    logic                      reg_form;
    logic                      imm_form;
    logic                      fixed_shift;

    assign opcode = mips_isa_pkg::opcode_of(instr);
    assign funct  = mips_isa_pkg::funct_of(instr);
    assign rs     = mips_isa_pkg::rs_of(instr);
    assign rt     = mips_isa_pkg::rt_of(instr);
    assign rd     = mips_isa_pkg::rd_of(instr);

    always_comb begin
        op = decode_ctl_pkg::RESERVED;
        reg_form = 1'b0;
        imm_form = 1'b0;
        if (opcode == `OP_SPECIAL) begin
            reg_form = 1'b1;
            case (funct)
                `F_ADD:  op = decode_ctl_pkg::ADD;
                `F_ADDU: op = decode_ctl_pkg::ADDU;
                `F_SUB:  op = decode_ctl_pkg::SUB;
                `F_SUBU: op = decode_ctl_pkg::SUBU;
                `F_SLT:  op = decode_ctl_pkg::SLT;
                `F_SLTU: op = decode_ctl_pkg::SLTU;
                `F_AND:  op = decode_ctl_pkg::AND;
                `F_OR:   op = decode_ctl_pkg::OR;
                `F_XOR:  op = decode_ctl_pkg::XOR;
                `F_NOR:  op = decode_ctl_pkg::NOR;
                `F_SLL:  op = decode_ctl_pkg::SLL;
                `F_SRL:  op = decode_ctl_pkg::SRL;
                `F_SRA:  op = decode_ctl_pkg::SRA;
                `F_SLLV: op = decode_ctl_pkg::SLLV;
                `F_SRLV: op = decode_ctl_pkg::SRLV;
                `F_SRAV: op = decode_ctl_pkg::SRAV;
                default: reg_form = 1'b0;  // JR/JALR belong to the jump decoder
            endcase
        end else begin
            imm_form = 1'b1;
            case (opcode)
                `OP_ADDI:  op = decode_ctl_pkg::ADD;
                `OP_ADDIU: op = decode_ctl_pkg::ADDU;
                `OP_SLTI:  op = decode_ctl_pkg::SLT;
                `OP_SLTIU: op = decode_ctl_pkg::SLTU;
                `OP_ANDI:  op = decode_ctl_pkg::AND;
                `OP_ORI:   op = decode_ctl_pkg::OR;
                `OP_XORI:  op = decode_ctl_pkg::XOR;
                `OP_LUI:   op = decode_ctl_pkg::LUI;
                default:   imm_form = 1'b0;
            endcase
        end
    end

    // immediate forms share the register-form ALU function
    always_comb begin
        case (op)
            decode_ctl_pkg::ADD:  alufunc = decode_ctl_pkg::ALU_ADD;
            decode_ctl_pkg::ADDU: alufunc = decode_ctl_pkg::ALU_ADDU;
            decode_ctl_pkg::SUB:  alufunc = decode_ctl_pkg::ALU_SUB;
            decode_ctl_pkg::SUBU: alufunc = decode_ctl_pkg::ALU_SUBU;
            decode_ctl_pkg::SLT:  alufunc = decode_ctl_pkg::ALU_SLT;
            decode_ctl_pkg::SLTU: alufunc = decode_ctl_pkg::ALU_SLTU;
            decode_ctl_pkg::AND:  alufunc = decode_ctl_pkg::ALU_AND;
            decode_ctl_pkg::OR:   alufunc = decode_ctl_pkg::ALU_OR;
            decode_ctl_pkg::XOR:  alufunc = decode_ctl_pkg::ALU_XOR;
            decode_ctl_pkg::NOR:  alufunc = decode_ctl_pkg::ALU_NOR;
            decode_ctl_pkg::SLL, decode_ctl_pkg::SLLV: alufunc = decode_ctl_pkg::ALU_SLL;
            decode_ctl_pkg::SRL, decode_ctl_pkg::SRLV: alufunc = decode_ctl_pkg::ALU_SRL;
            decode_ctl_pkg::SRA, decode_ctl_pkg::SRAV: alufunc = decode_ctl_pkg::ALU_SRA;
            decode_ctl_pkg::LUI:  alufunc = decode_ctl_pkg::ALU_LUI;
            default:              alufunc = decode_ctl_pkg::ALU_PASSA;
        endcase
    end

    assign hit = reg_form | imm_form;
    assign fixed_shift = reg_form
        && (op inside {decode_ctl_pkg::SLL, decode_ctl_pkg::SRL, decode_ctl_pkg::SRA});

    always_comb begin
        result = '0;
        if (hit) begin
            result.op = op;
            result.ctl.alufunc = alufunc;
            result.ctl.regwrite = 1'b1;
            if (reg_form) begin
                result.ctl.alusrc = decode_ctl_pkg::REGB;
                result.ctl.shamt_valid = fixed_shift;
                result.srcrega = fixed_shift ? '0 : rs;  // shift source is rt only
                result.srcregb = rt;
                result.destreg = rd;
            end else begin
                result.ctl.alusrc = decode_ctl_pkg::IMM;
                result.ctl.zeroext = op inside {decode_ctl_pkg::AND, decode_ctl_pkg::OR,
                                                decode_ctl_pkg::XOR};
                result.srcrega = (op == decode_ctl_pkg::LUI) ? '0 : rs;
                result.destreg = rt;
            end
        end
    end

    a_op_mapped: assert property (@(instr) result.op != decode_ctl_pkg::RESERVED
        |-> result.ctl.alufunc != decode_ctl_pkg::ALU_PASSA)
        else $error("alu op decoded without an ALU function");

endmodule

/* design/branch_jump_decode.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module branch_jump_decode (
    input  mips_isa_pkg::word_t         instr,
    output logic                        hit,
    output decode_ctl_pkg::decode_out_t result
);
    mips_isa_pkg::opcode_t        opcode;
    mips_isa_pkg::func_t          funct;
    mips_isa_pkg::reg_addr_t      rs;
    mips_isa_pkg::reg_addr_t      rt;
    decode_ctl_pkg::decoded_op_e  op;
    decode_ctl_pkg::branch_type_e btype;
    logic                         br_two;
    logic                         br_zero;
    logic                         reg_jump;
    logic                         link;

    assign opcode = mips_isa_pkg::opcode_of(instr);
    assign funct  = mips_isa_pkg::funct_of(instr);
    assign rs     = mips_isa_pkg::rs_of(instr);
    assign rt     = mips_isa_pkg::rt_of(instr);

    always_comb begin
        op = decode_ctl_pkg::RESERVED;
        hit = 1'b1;
        case (opcode)
            `OP_BEQ:  op = decode_ctl_pkg::BEQ;
            `OP_BNE:  op = decode_ctl_pkg::BNE;
            `OP_BGTZ: op = decode_ctl_pkg::BGTZ;
            `OP_BLEZ: op = decode_ctl_pkg::BLEZ;
            `OP_J:    op = decode_ctl_pkg::J;
            `OP_JAL:  op = decode_ctl_pkg::JAL;
            `OP_REGIMM: begin
                case (rt)  // rt selects the REGIMM branch
                    `B_BGEZ:   op = decode_ctl_pkg::BGEZ;
                    `B_BLTZ:   op = decode_ctl_pkg::BLTZ;
                    `B_BGEZAL: op = decode_ctl_pkg::BGEZAL;
                    `B_BLTZAL: op = decode_ctl_pkg::BLTZAL;
                    default:   hit = 1'b0;
                endcase
            end
            `OP_SPECIAL: begin
                case (funct)
                    `F_JR:   op = decode_ctl_pkg::JR;
                    `F_JALR: op = decode_ctl_pkg::JALR;
                    default: hit = 1'b0;
                endcase
            end
            default: hit = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            decode_ctl_pkg::BNE:  btype = decode_ctl_pkg::T_BNE;
            decode_ctl_pkg::BGEZ, decode_ctl_pkg::BGEZAL: btype = decode_ctl_pkg::T_BGEZ;
            decode_ctl_pkg::BLTZ, decode_ctl_pkg::BLTZAL: btype = decode_ctl_pkg::T_BLTZ;
            decode_ctl_pkg::BGTZ: btype = decode_ctl_pkg::T_BGTZ;
            decode_ctl_pkg::BLEZ: btype = decode_ctl_pkg::T_BLEZ;
            default:              btype = decode_ctl_pkg::T_BEQ;
        endcase
    end

    assign br_two   = op inside {decode_ctl_pkg::BEQ, decode_ctl_pkg::BNE};
    assign br_zero  = op inside {decode_ctl_pkg::BGEZ, decode_ctl_pkg::BLTZ,
                                 decode_ctl_pkg::BGEZAL, decode_ctl_pkg::BLTZAL,
                                 decode_ctl_pkg::BGTZ, decode_ctl_pkg::BLEZ};
    assign reg_jump = op inside {decode_ctl_pkg::JR, decode_ctl_pkg::JALR};
    assign link     = op inside {decode_ctl_pkg::BGEZAL, decode_ctl_pkg::BLTZAL,
                                 decode_ctl_pkg::JAL, decode_ctl_pkg::JALR};

    always_comb begin
        result = '0;
        if (hit) begin
            result.op = op;
            result.ctl.branch = br_two | br_zero;
            result.ctl.branch1 = br_zero;
            result.ctl.branch2 = br_two;
            result.ctl.branch_type = btype;
            result.ctl.jump = !(br_two | br_zero);
            result.ctl.jr = reg_jump;
            result.ctl.alufunc = reg_jump ? decode_ctl_pkg::ALU_PASSA : decode_ctl_pkg::ALU_ADDU;
            result.ctl.regwrite = link;  // return address write
            result.ctl.is_link = link;
            result.srcrega = (op inside {decode_ctl_pkg::J, decode_ctl_pkg::JAL}) ? '0 : rs;
            result.srcregb = br_two ? rt : '0;
            result.destreg = link ? `LINK_REG : '0;
        end
    end

    a_one_kind: assert property (@(instr)
        result.ctl.branch |-> result.ctl.branch1 != result.ctl.branch2)
        else $error("branch is not exactly one compare kind");

endmodule

/* design/mem_op_decode.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module mem_op_decode (
    input  mips_isa_pkg::word_t         instr,
    output logic                        hit,
    output decode_ctl_pkg::decode_out_t result
);
    mips_isa_pkg::opcode_t       opcode;
    mips_isa_pkg::reg_addr_t     rs;
    mips_isa_pkg::reg_addr_t     rt;
    decode_ctl_pkg::decoded_op_e op;
    logic                        is_store;

    assign opcode = mips_isa_pkg::opcode_of(instr);
    assign rs     = mips_isa_pkg::rs_of(instr);
    assign rt     = mips_isa_pkg::rt_of(instr);

    always_comb begin
        op = decode_ctl_pkg::RESERVED;
        hit = 1'b1;
        case (opcode)
            `OP_LB:  op = decode_ctl_pkg::LB;
            `OP_LBU: op = decode_ctl_pkg::LBU;
            `OP_LH:  op = decode_ctl_pkg::LH;
            `OP_LHU: op = decode_ctl_pkg::LHU;
            `OP_LW:  op = decode_ctl_pkg::LW;
            `OP_LWL: op = decode_ctl_pkg::LWL;
            `OP_LWR: op = decode_ctl_pkg::LWR;
            `OP_SB:  op = decode_ctl_pkg::SB;
            `OP_SH:  op = decode_ctl_pkg::SH;
            `OP_SW:  op = decode_ctl_pkg::SW;
            `OP_SWL: op = decode_ctl_pkg::SWL;
            `OP_SWR: op = decode_ctl_pkg::SWR;
            default: hit = 1'b0;
        endcase
    end

    assign is_store = op inside {decode_ctl_pkg::SB, decode_ctl_pkg::SH, decode_ctl_pkg::SW,
                                 decode_ctl_pkg::SWL, decode_ctl_pkg::SWR};

    always_comb begin
        result = '0;
        if (hit) begin
            result.op = op;
            result.ctl.alusrc = decode_ctl_pkg::IMM;  // base plus offset
            result.ctl.memwrite = is_store;
            result.ctl.memtoreg = !is_store;
            result.ctl.regwrite = !is_store;
            result.srcrega = rs;
            result.srcregb = is_store ? rt : '0;  // store data
            result.destreg = is_store ? '0 : rt;
        end
    end

endmodule

/* design/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        instr_valid,
    input  mips_isa_pkg::word_t         instr,
    output logic                        dec_valid,
    output decode_ctl_pkg::decode_out_t dec
);
    logic                        alu_hit;
    logic                        bj_hit;
    logic                        mem_hit;
    logic                        any_hit;
    decode_ctl_pkg::decode_out_t alu_res;
    decode_ctl_pkg::decode_out_t bj_res;
    decode_ctl_pkg::decode_out_t mem_res;
    decode_ctl_pkg::decode_out_t merged;
    decode_ctl_pkg::decode_out_t next_dec;

    alu_op_decode u_alu (
        .instr  (instr),
        .hit    (alu_hit),
        .result (alu_res)
    );

    branch_jump_decode u_bj (
        .instr  (instr),
        .hit    (bj_hit),
        .result (bj_res)
    );

    mem_op_decode u_mem (
        .instr  (instr),
        .hit    (mem_hit),
        .result (mem_res)
    );

    assign any_hit = alu_hit | bj_hit | mem_hit;
    assign merged  = alu_res | bj_res | mem_res;  // non-claiming peers are all zero

    always_comb begin
        next_dec = merged;
        if (!any_hit) begin
            next_dec = '0;
            next_dec.op = decode_ctl_pkg::RESERVED;
            next_dec.exception_ri = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            dec <= '0;
        end else begin
            dec_valid <= instr_valid;
            if (instr_valid) begin
                dec <= next_dec;  // holds when idle
            end
        end
    end

    a_one_claim: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({alu_hit, bj_hit, mem_hit}))
        else $error("more than one group decoder claimed the instruction");

    // only the reserved path may carry the RI flag
    a_ri_match: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid |-> dec.exception_ri == (dec.op == decode_ctl_pkg::RESERVED))
        else $error("reserved flag and decoded op disagree");

endmodule

/* dv/tb_instr_decode.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module tb_instr_decode;
    logic                        clk;
    logic                        rst_n;
    logic                        instr_valid;
    mips_isa_pkg::word_t         instr;
    logic                        dec_valid;
    decode_ctl_pkg::decode_out_t dec;

    string                       test_name [$];
    mips_isa_pkg::word_t         test_instr [$];
    decode_ctl_pkg::decode_out_t test_exp [$];
    string                       pend_name [$];  // in flight, oldest first
    decode_ctl_pkg::decode_out_t pend_exp [$];
    decode_ctl_pkg::decode_out_t held_exp = '0;  // what dec keeps while idle
    logic                        prev_valid = 1'b0;
    int                          checks = 0;
    int                          mismatches = 0;
    int                          other_errors = 0;
    mips_isa_pkg::opcode_t       dropped_ops [6] = '{`OP_SPECIAL2, `OP_COP0, `OP_CACHE,
                                                     `OP_PREF, `OP_LL, `OP_SC};

    instr_decode dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec_valid   (dec_valid),
        .dec         (dec)
    );

    always #20 clk = ~clk;

    task automatic check_op(input string name, input decode_ctl_pkg::decoded_op_e exp,
                            input decode_ctl_pkg::decoded_op_e act);
        if (exp !== act) begin
            $display("Mismatch %s op: expected %s actual %s", name, exp.name(), act.name());
            mismatches++;
        end
    endtask

    task automatic check_ctl(input string name, input decode_ctl_pkg::control_t exp,
                             input decode_ctl_pkg::control_t act);
        if (exp !== act) begin
            $display("Mismatch %s ctl: expected %h actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_reg(input string name, input mips_isa_pkg::reg_addr_t exp,
                             input mips_isa_pkg::reg_addr_t act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %0d actual %0d", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %b actual %b", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic compare_decode(input string name, input decode_ctl_pkg::decode_out_t exp);
        checks++;
        check_op(name, exp.op, dec.op);
        check_ctl(name, exp.ctl, dec.ctl);
        check_reg({name, " srcrega"}, exp.srcrega, dec.srcrega);
        check_reg({name, " srcregb"}, exp.srcregb, dec.srcregb);
        check_reg({name, " destreg"}, exp.destreg, dec.destreg);
        check_flag({name, " exception_ri"}, exp.exception_ri, dec.exception_ri);
    endtask

    function automatic bit lookup_op(input string s, output decode_ctl_pkg::decoded_op_e e);
        decode_ctl_pkg::decoded_op_e v;
        int k;
        v = v.first();
        e = v;
        for (k = 0; k < v.num(); k++) begin
            if (v.name() == s) begin
                e = v;
                return 1'b1;
            end
            v = v.next();
        end
        return 1'b0;
    endfunction

    function automatic bit lookup_alu(input string s, output decode_ctl_pkg::alu_func_e e);
        decode_ctl_pkg::alu_func_e v;
        int k;
        v = v.first();
        e = v;
        for (k = 0; k < v.num(); k++) begin
            if (v.name() == s) begin
                e = v;
                return 1'b1;
            end
            v = v.next();
        end
        return 1'b0;
    endfunction

    function automatic bit lookup_branch(input string s,
                                         output decode_ctl_pkg::branch_type_e e);
        decode_ctl_pkg::branch_type_e v;
        int k;
        v = v.first();
        e = v;
        for (k = 0; k < v.num(); k++) begin
            if (v.name() == s) begin
                e = v;
                return 1'b1;
            end
            v = v.next();
        end
        return 1'b0;
    endfunction

    // what any unclaimed instruction must decode to
    function automatic decode_ctl_pkg::decode_out_t reserved_result();
        decode_ctl_pkg::decode_out_t r;
        r = '0;
        r.op = decode_ctl_pkg::RESERVED;
        r.exception_ri = 1'b1;
        return r;
    endfunction

    task automatic load_tests();
        int                           fd;
        int                           n;
        int                           code;
        string                        line;
        string                        name;
        string                        op_s;
        string                        alu_s;
        string                        bt_s;
        mips_isa_pkg::word_t          w;
        logic [11:0]                  flags;
        mips_isa_pkg::reg_addr_t      sa;
        mips_isa_pkg::reg_addr_t      sb;
        mips_isa_pkg::reg_addr_t      dst;
        logic                         ri;
        decode_ctl_pkg::decoded_op_e  op_e;
        decode_ctl_pkg::alu_func_e    alu_e;
        decode_ctl_pkg::branch_type_e bt_e;
        decode_ctl_pkg::decode_out_t  exp;
        fd = $fopen("dv/decode_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test file dv/decode_tests.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %s %s %s %b %d %d %d %b",
                        name, w, op_s, alu_s, bt_s, flags, sa, sb, dst, ri);
            if (n != 10 || !lookup_op(op_s, op_e) || !lookup_alu(alu_s, alu_e)
                    || !lookup_branch(bt_s, bt_e)) begin
                $display("could not parse test line: %s", line);
                other_errors++;
                continue;
            end
            exp = '0;
            exp.op = op_e;
            exp.ctl.alufunc = alu_e;
            exp.ctl.alusrc = flags[11] ? decode_ctl_pkg::IMM : decode_ctl_pkg::REGB;
            exp.ctl.branch_type = bt_e;
            exp.ctl.regwrite = flags[10];
            exp.ctl.memtoreg = flags[9];
            exp.ctl.memwrite = flags[8];
            exp.ctl.zeroext = flags[7];
            exp.ctl.shamt_valid = flags[6];
            exp.ctl.branch = flags[5];
            exp.ctl.branch1 = flags[4];
            exp.ctl.branch2 = flags[3];
            exp.ctl.jump = flags[2];
            exp.ctl.jr = flags[1];
            exp.ctl.is_link = flags[0];
            exp.srcrega = sa;
            exp.srcregb = sb;
            exp.destreg = dst;
            exp.exception_ri = ri;
            test_name.push_back(name);
            test_instr.push_back(w);
            test_exp.push_back(exp);
        end
        $fclose(fd);
    endtask

    task automatic drive_instr(input string name, input mips_isa_pkg::word_t w,
                               input decode_ctl_pkg::decode_out_t exp);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr <= w;
        pend_name.push_back(name);
        pend_exp.push_back(exp);
    endtask

    task automatic drive_idle();
        @(posedge clk);
        instr_valid <= 1'b0;
        instr <= $urandom;  // must not reach dec
    endtask

    // dec_valid must follow instr_valid by exactly one cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (dec_valid !== prev_valid) begin
                $display("dec_valid was %b one cycle after instr_valid was %b",
                         dec_valid, prev_valid);
                other_errors++;
            end
            if (dec_valid === 1'b1) begin
                if (pend_exp.size() == 0) begin
                    $display("decoded output was valid with no instruction in flight");
                    other_errors++;
                end else begin
                    held_exp = pend_exp[0];
                    compare_decode(pend_name.pop_front(), pend_exp.pop_front());
                end
            end else begin
                compare_decode("idle hold", held_exp);
            end
            prev_valid = instr_valid;
        end
    end

    initial begin
        int                    i;
        int                    wait_cycles;
        mips_isa_pkg::opcode_t opc;
        mips_isa_pkg::word_t   w;
        clk = 1'b0;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        void'($urandom(32'hfef75feb));
        load_tests();
        if (test_exp.size() == 0) begin
            $display("no tests were read from the test file");
            other_errors++;
        end

        repeat (7) @(posedge clk);
        @(negedge clk);
        check_flag("reset dec_valid", 1'b0, dec_valid);
        compare_decode("reset", '0);
        @(posedge clk);
        rst_n <= 1'b1;

        for (i = 0; i < test_exp.size(); i++) begin
            drive_instr(test_name[i], test_instr[i], test_exp[i]);
            if (i == 10 || i == 30) begin
                drive_idle();
            end
        end

        // dropped opcodes with random low bits
        for (i = 0; i < 40; i++) begin
            opc = dropped_ops[$urandom % 6];
            w = {opc, 26'($urandom)};
            drive_instr($sformatf("rand_%0d_%h", i, w), w, reserved_result());
            if ($urandom % 4 == 0) begin
                drive_idle();
            end
        end
        drive_idle();

        wait_cycles = 0;
        while (pend_exp.size() != 0 && wait_cycles < 10) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (pend_exp.size() != 0) begin
            $display("the decoded output never became valid for %0d instructions",
                     pend_exp.size());
            other_errors++;
        end
        @(posedge clk);

        $display("checks: %0d  mismatches: %0d  other errors: %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* dv/decode_tests.txt */
# name instr op alufunc branch_type flags srcrega srcregb destreg exception_ri
# flags: alusrc regwrite memtoreg memwrite zeroext shamt_valid branch branch1 branch2 jump jr is_link
add_r3       00221820 ADD      ALU_ADD   T_BEQ  010000000000  1  2  3 0
addu_r1      00430821 ADDU     ALU_ADDU  T_BEQ  010000000000  2  3  1 0
subu_r10     01095023 SUBU     ALU_SUBU  T_BEQ  010000000000  8  9 10 0
slt_r4       00A6202A SLT      ALU_SLT   T_BEQ  010000000000  5  6  4 0
nor_r7       00E03827 NOR      ALU_NOR   T_BEQ  010000000000  7  0  7 0
sll_r2       00031100 SLL      ALU_SLL   T_BEQ  010001000000  0  3  2 0
sra_r9       000A4FC3 SRA      ALU_SRA   T_BEQ  010001000000  0 10  9 0
srlv_r5      00E62806 SRLV     ALU_SRL   T_BEQ  010000000000  7  6  5 0
addi_r2      2022FFFF ADD      ALU_ADD   T_BEQ  110000000000  1  0  2 0
slti_r3      28830005 SLT      ALU_SLT   T_BEQ  110000000000  4  0  3 0
sltiu_r6     2CE60064 SLTU     ALU_SLTU  T_BEQ  110000000000  7  0  6 0
andi_r5      30C500FF AND      ALU_AND   T_BEQ  110010000000  6  0  5 0
ori_r8       35281234 OR       ALU_OR    T_BEQ  110010000000  9  0  8 0
xori_r1      3821FFFF XOR      ALU_XOR   T_BEQ  110010000000  1  0  1 0
lui_r4       3C04ABCD LUI      ALU_LUI   T_BEQ  110000000000  0  0  4 0
beq_r1_r2    10220010 BEQ      ALU_ADDU  T_BEQ  000000101000  1  2  0 0
bne_r3_r4    1464FFFC BNE      ALU_ADDU  T_BNE  000000101000  3  4  0 0
bgtz_r5      1CA00008 BGTZ     ALU_ADDU  T_BGTZ 000000110000  5  0  0 0
blez_r6      18C00008 BLEZ     ALU_ADDU  T_BLEZ 000000110000  6  0  0 0
bltz_r7      04E00004 BLTZ     ALU_ADDU  T_BLTZ 000000110000  7  0  0 0
bgez_r8      05010004 BGEZ     ALU_ADDU  T_BGEZ 000000110000  8  0  0 0
bltzal_r9    05300004 BLTZAL   ALU_ADDU  T_BLTZ 010000110001  9  0 31 0
bgezal_r10   05510004 BGEZAL   ALU_ADDU  T_BGEZ 010000110001 10  0 31 0
j_far        08000100 J        ALU_ADDU  T_BEQ  000000000100  0  0  0 0
jal_far      0C000040 JAL      ALU_ADDU  T_BEQ  010000000101  0  0 31 0
jr_ra        03E00008 JR       ALU_PASSA T_BEQ  000000000110 31  0  0 0
jalr_r4      0080F809 JALR     ALU_PASSA T_BEQ  010000000111  4  0 31 0
lw_sp        8FA20008 LW       ALU_ADDU  T_BEQ  111000000000 29  0  2 0
lb_r3        80830000 LB       ALU_ADDU  T_BEQ  111000000000  4  0  3 0
lbu_r2       90620000 LBU      ALU_ADDU  T_BEQ  111000000000  3  0  2 0
lhu_r5       94C50002 LHU      ALU_ADDU  T_BEQ  111000000000  6  0  5 0
lwl_r7       89070003 LWL      ALU_ADDU  T_BEQ  111000000000  8  0  7 0
lwr_r7       99070000 LWR      ALU_ADDU  T_BEQ  111000000000  8  0  7 0
sw_sp        AFA20004 SW       ALU_ADDU  T_BEQ  100100000000 29  2  0 0
sb_r3        A0830001 SB       ALU_ADDU  T_BEQ  100100000000  4  3  0 0
sh_r2        A4220002 SH       ALU_ADDU  T_BEQ  100100000000  1  2  0 0
swl_r4       A8A40000 SWL      ALU_ADDU  T_BEQ  100100000000  5  4  0 0
swr_r9       B9490000 SWR      ALU_ADDU  T_BEQ  100100000000 10  9  0 0
mul_special2 70221802 RESERVED ALU_ADDU  T_BEQ  000000000000  0  0  0 1
mfc0         40026000 RESERVED ALU_ADDU  T_BEQ  000000000000  0  0  0 1
cache        BC800000 RESERVED ALU_ADDU  T_BEQ  000000000000  0  0  0 1
pref         CC800004 RESERVED ALU_ADDU  T_BEQ  000000000000  0  0  0 1
ll           C0820000 RESERVED ALU_ADDU  T_BEQ  000000000000  0  0  0 1
sync         0000000F RESERVED ALU_ADDU  T_BEQ  000000000000  0  0  0 1
syscall      0000000C RESERVED ALU_ADDU  T_BEQ  000000000000  0  0  0 1
movz         0062200A RESERVED ALU_ADDU  T_BEQ  000000000000  0  0  0 1
regimm_bad   04220004 RESERVED ALU_ADDU  T_BEQ  000000000000  0  0  0 1

/* vlog.f */
+incdir+design
design/mips_isa_pkg.sv
design/decode_ctl_pkg.sv
design/alu_op_decode.sv
design/branch_jump_decode.sv
design/mem_op_decode.sv
design/instr_decode.sv
dv/tb_instr_decode.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_instr_decode \
		-f vlog.f -o tb_instr_decode
	./obj_dir/tb_instr_decode | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
